// File: project.f
logic/ext_mem_pkg.sv
logic/line_cache.sv
logic/bus_merge.sv
logic/ext_mem.sv
bench/clk_gen.sv
bench/ext_mem_chk.sv
bench/ext_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
   --top-module ext_mem_tb -Mdir obj_dir -o sim_ext_mem

out=$(./obj_dir/sim_ext_mem || true)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
   exit 0
else
   exit 1
fi

// File: bench/ext_mem_tb.sv
`timescale 1ns/100ps

module ext_mem_tb;

   localparam int AW       = ext_mem_pkg::ADDR_W_DEF - 2;
   localparam int DW       = ext_mem_pkg::DATA_W;
   localparam int SW       = ext_mem_pkg::STRB_W;
   localparam int N_SEQ    = 100;   // Single port reads
   localparam int N_PAIR   = 100;   // Concurrent read pairs
   localparam int N_WR     = 60;    // Writes, each with an own port read
   localparam int N_REP    = 20;    // Read then repeat read
   localparam int N_OPS    = N_SEQ + 2 * N_PAIR + 3 * N_WR + 2 * N_REP + 4;
   localparam int LIMIT    = 40 * N_OPS;
   localparam int HIT_NEG  = 2;     // Negedges from req to ack on an L1 hit

   logic clk, arst;
   logic i_req, d_req, d_inv;
   logic [AW-1:0] i_addr, d_addr;
   logic [DW-1:0] i_wdata, d_wdata, i_rdata, d_rdata;
   logic [SW-1:0] i_wstrb, d_wstrb;
   logic i_ack, d_ack;
   logic mem_req, mem_ack;
   logic [AW-1:0] mem_addr;
   logic [DW-1:0] mem_wdata, mem_rdata;
   logic [SW-1:0] mem_wstrb;

   logic [DW-1:0] mem [1 << AW];
   logic [DW-1:0] shadow [1 << AW];
   logic [AW-1:0] wr_addr_q[$];
   logic [DW-1:0] wr_data_q[$];
   logic [SW-1:0] wr_strb_q[$];
   int mem_xfers;
   int cycles;

   clk_gen #(.PERIOD(20), .RST_CYCLES(3)) clk_gen_i (.clk_o(clk), .arst_o(arst));

   ext_mem ext_mem_i (
      .clk_i(clk), .arst_i(arst),
      .i_req_i(i_req), .i_addr_i(i_addr), .i_wdata_i(i_wdata), .i_wstrb_i(i_wstrb),
      .i_rdata_o(i_rdata), .i_ack_o(i_ack),
      .d_req_i(d_req), .d_addr_i(d_addr), .d_wdata_i(d_wdata), .d_wstrb_i(d_wstrb),
      .d_invalidate_i(d_inv), .d_rdata_o(d_rdata), .d_ack_o(d_ack),
      .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
      .mem_wstrb_o(mem_wstrb), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERROR: time %0t signal %s actual %h expected %h",
                  $time, name, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "check failed");
      end
   endtask

   function automatic logic [AW-1:0] rand_addr(input int base, input int span);
      logic [31:0] r;
      r = base + ($urandom % span);
      return r[AW-1:0];
   endfunction

   // One front-end transfer on the instruction port (1) or the data port (0)
   task automatic access(input bit port, input logic [AW-1:0] addr,
                         input logic [DW-1:0] wdata, input logic [SW-1:0] wstrb,
                         output logic [DW-1:0] rdata, output int lat);
      @(posedge clk);
      if (port) begin
         i_req   <= 1'b1;
         i_addr  <= addr;
         i_wdata <= wdata;
         i_wstrb <= wstrb;
      end else begin
         d_req   <= 1'b1;
         d_addr  <= addr;
         d_wdata <= wdata;
         d_wstrb <= wstrb;
      end
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!(port ? i_ack : d_ack));
      rdata = port ? i_rdata : d_rdata;
      @(posedge clk);
      if (port) i_req <= 1'b0;
      else d_req <= 1'b0;
   endtask

   task automatic read_check(input bit port, input logic [AW-1:0] addr, output int lat);
      logic [DW-1:0] rd;
      access(port, addr, $urandom, '0, rd, lat);
      check_value(port ? "i_rdata_o" : "d_rdata_o", rd, shadow[addr]);
   endtask

   task automatic write_word(input bit port, input logic [AW-1:0] addr);
      logic [DW-1:0] wd;
      logic [31:0] r;
      logic [DW-1:0] rd;
      int lat;
      bit found;
      wd = $urandom;
      r = ($urandom % 15) + 1;   // Never all-zero
      access(port, addr, wd, r[SW-1:0], rd, lat);
      found = 0;
      for (int i = 0; i < wr_addr_q.size(); i++) begin
         if (!found && wr_addr_q[i] == addr && wr_data_q[i] == wd &&
             wr_strb_q[i] == r[SW-1:0]) begin
            found = 1;
            wr_addr_q.delete(i);
            wr_data_q.delete(i);
            wr_strb_q.delete(i);
         end
      end
      check_value("mem write seen", 32'(found), 32'd1);
      for (int b = 0; b < SW; b++)
         if (r[b]) shadow[addr][8*b +: 8] = wd[8*b +: 8];
   endtask

   task automatic invalidate_and_settle();
      @(posedge clk);
      d_inv <= 1'b1;
      @(posedge clk);
      d_inv <= 1'b0;
      repeat (5) @(posedge clk);   // L2 drops its lines once idle
   endtask

   // Memory model with 0 to 3 cycles of random delay
   initial begin
      logic [31:0] r;
      logic [AW-1:0] a;
      logic [DW-1:0] wd;
      logic [SW-1:0] ws;
      mem_ack = 1'b0;
      mem_rdata = '0;
      mem_xfers = 0;
      wait (!arst);
      forever begin
         @(negedge clk);
         if (mem_req) begin
            r = $urandom % 4;
            repeat (r) @(negedge clk);
            a = mem_addr;
            wd = mem_wdata;
            ws = mem_wstrb;
            mem_xfers++;
            @(posedge clk);
            mem_ack <= 1'b1;
            mem_rdata <= mem[a];
            if (ws != '0) begin
               for (int b = 0; b < SW; b++)
                  if (ws[b]) mem[a][8*b +: 8] = wd[8*b +: 8];
               wr_addr_q.push_back(a);
               wr_data_q.push_back(wd);
               wr_strb_q.push_back(ws);
            end
            @(posedge clk);
            mem_ack <= 1'b0;
         end
      end
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= LIMIT) begin
            $display("Timeout: requests did not complete within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      logic [AW-1:0] a, b;
      logic [AW-1:0] wa [N_WR];
      bit wp [N_WR];
      int lat, lat2;
      int xfers_before;
      void'($urandom(11635));
      i_req = 1'b0;
      i_addr = '0;
      i_wdata = '0;
      i_wstrb = '0;
      d_req = 1'b0;
      d_addr = '0;
      d_wdata = '0;
      d_wstrb = '0;
      d_inv = 1'b0;
      for (int k = 0; k < (1 << AW); k++) begin
         mem[k] = $urandom;
         shadow[k] = mem[k];
      end
      wait (!arst);

      // Reads alone and together over 512 words
      for (int n = 0; n < N_SEQ; n++)
         read_check(1'($urandom % 2), rand_addr(0, 512), lat);
      for (int n = 0; n < N_PAIR; n++) begin
         a = rand_addr(0, 512);
         b = rand_addr(0, 512);
         fork
            read_check(1'b0, a, lat);
            read_check(1'b1, b, lat2);
         join
      end

      // Data writes go to the low half and instruction writes to the high half
      for (int n = 0; n < N_WR; n++) begin
         wp[n] = 1'($urandom % 2);
         wa[n] = wp[n] ? rand_addr(256, 256) : rand_addr(0, 256);
         write_word(wp[n], wa[n]);
         read_check(wp[n], wa[n], lat);
      end
      invalidate_and_settle();
      for (int n = 0; n < N_WR; n++)
         read_check(!wp[n], wa[n], lat);

      // Repeat read must hit in L1
      for (int n = 0; n < N_REP; n++) begin
         a = rand_addr(0, 512);
         b = {{(AW-1){1'b0}}, 1'($urandom % 2)};
         read_check(b[0], a, lat);
         read_check(b[0], a, lat);
         check_value("hit latency", lat, HIT_NEG);
      end

      // Invalidate forces both ports back to memory
      a = rand_addr(0, 256);
      b = rand_addr(256, 256);
      read_check(1'b0, a, lat);
      read_check(1'b1, b, lat);
      invalidate_and_settle();
      xfers_before = mem_xfers;
      read_check(1'b1, b, lat);
      check_value("mem_req_o after invalidate", 32'(mem_xfers > xfers_before), 32'd1);
      xfers_before = mem_xfers;
      read_check(1'b0, a, lat);
      check_value("mem_req_o after invalidate", 32'(mem_xfers > xfers_before), 32'd1);

      if (wr_addr_q.size() == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("Memory saw writes that no front-end write accounts for");
         $display("STATUS: FAIL");
         $fatal(1, "stray writes");
      end
   end

endmodule

// File: bench/ext_mem_chk.sv
`timescale 1ns/100ps

module ext_mem_chk #(
   parameter int ADDR_W = ext_mem_pkg::ADDR_W_DEF
) (
   input logic                            clk_i,
   input logic                            arst_i,
   input logic                            i_ack_i,
   input logic                            d_ack_i,
   input logic                            mem_req_i,
   input logic                            mem_ack_i,
   input logic [ADDR_W-3:0]               mem_addr_i,
   input logic [ext_mem_pkg::DATA_W-1:0]  mem_wdata_i,
   input logic                            l2_req_i,
   input logic                            l2_inv_i
);

   // Quiet outputs coming out of reset
   reset_quiet: assert property (@(posedge clk_i)
      $fell(arst_i) |-> (!i_ack_i && !d_ack_i && !mem_req_i))
      else $error("ack or memory request high right after reset");

   i_ack_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      i_ack_i |=> !i_ack_i)
      else $error("i_ack_o held longer than one cycle");

   d_ack_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      d_ack_i |=> !d_ack_i)
      else $error("d_ack_o held longer than one cycle");

   // L2 clears its lines only while nothing is requested of it
   l2_inv_idle: assert property (@(posedge clk_i) disable iff (arst_i)
      !(l2_inv_i && l2_req_i))
      else $error("L2 invalidate while L2 request is high");

   // Memory request held steady until acked
   mem_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      (mem_req_i && !mem_ack_i) |=> ($stable(mem_addr_i) && $stable(mem_wdata_i)))
      else $error("memory address or write data changed before ack");

endmodule

bind ext_mem ext_mem_chk #(.ADDR_W(ADDR_W)) chk_i (
   .clk_i(clk_i), .arst_i(arst_i),
   .i_ack_i(i_ack_o), .d_ack_i(d_ack_o),
   .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i),
   .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
   .l2_req_i(l2_req), .l2_inv_i(l2cache.invalidate_o)
);

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic arst_o
);

   initial begin
      clk_o  = 1'b0;
      arst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      arst_o <= 1'b0;
   end

   always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: logic/ext_mem.sv
`timescale 1ns/100ps

module ext_mem #(
   parameter int ADDR_W     = ext_mem_pkg::ADDR_W_DEF,
   parameter int L1_INDEX_W = ext_mem_pkg::L1_INDEX_W_DEF,
   parameter int L2_INDEX_W = ext_mem_pkg::L2_INDEX_W_DEF,
   parameter int OFFSET_W   = ext_mem_pkg::OFFSET_W_DEF
) (
   input  logic                            clk_i,
   input  logic                            arst_i,
   // Instruction port
   input  logic                            i_req_i,
   input  logic [ADDR_W-3:0]               i_addr_i,
   input  logic [ext_mem_pkg::DATA_W-1:0]  i_wdata_i,
   input  logic [ext_mem_pkg::STRB_W-1:0]  i_wstrb_i,
   output logic [ext_mem_pkg::DATA_W-1:0]  i_rdata_o,
   output logic                            i_ack_o,
   // Data port
   input  logic                            d_req_i,
   input  logic [ADDR_W-3:0]               d_addr_i,
   input  logic [ext_mem_pkg::DATA_W-1:0]  d_wdata_i,
   input  logic [ext_mem_pkg::STRB_W-1:0]  d_wstrb_i,
   input  logic                            d_invalidate_i,
   output logic [ext_mem_pkg::DATA_W-1:0]  d_rdata_o,
   output logic                            d_ack_o,
   // External memory
   output logic                            mem_req_o,
   output logic [ADDR_W-3:0]               mem_addr_o,
   output logic [ext_mem_pkg::DATA_W-1:0]  mem_wdata_o,
   output logic [ext_mem_pkg::STRB_W-1:0]  mem_wstrb_o,
   input  logic [ext_mem_pkg::DATA_W-1:0]  mem_rdata_i,
   input  logic                            mem_ack_i
);

   logic                            ic_be_req, dc_be_req, l2_req;
   logic [ADDR_W-3:0]               ic_be_addr, dc_be_addr, l2_addr;
   logic [ext_mem_pkg::DATA_W-1:0]  ic_be_wdata, dc_be_wdata, l2_wdata;
   logic [ext_mem_pkg::STRB_W-1:0]  ic_be_wstrb, dc_be_wstrb, l2_wstrb;
   logic [ext_mem_pkg::DATA_W-1:0]  ic_be_rdata, dc_be_rdata, l2_rdata;
   logic                            ic_be_ack, dc_be_ack, l2_ack;
   logic                            dc_inv;           // Data cache just invalidated
   logic                            l2_inv_pending;

   // Hold the L2 invalidate until no refill or write is in flight
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i)
         l2_inv_pending <= 1'b0;
      else if (dc_inv)
         l2_inv_pending <= 1'b1;
      else if (!l2_req)
         l2_inv_pending <= 1'b0;
   end

   line_cache #(.ADDR_W(ADDR_W), .INDEX_W(L1_INDEX_W), .OFFSET_W(OFFSET_W)) icache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_req_i), .addr_i(i_addr_i), .wdata_i(i_wdata_i), .wstrb_i(i_wstrb_i),
      .rdata_o(i_rdata_o), .ack_o(i_ack_o),
      .invalidate_i(dc_inv), .invalidate_o(),
      .be_req_o(ic_be_req), .be_addr_o(ic_be_addr), .be_wdata_o(ic_be_wdata),
      .be_wstrb_o(ic_be_wstrb), .be_rdata_i(ic_be_rdata), .be_ack_i(ic_be_ack)
   );

   line_cache #(.ADDR_W(ADDR_W), .INDEX_W(L1_INDEX_W), .OFFSET_W(OFFSET_W)) dcache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(d_req_i), .addr_i(d_addr_i), .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
      .rdata_o(d_rdata_o), .ack_o(d_ack_o),
      .invalidate_i(d_invalidate_i), .invalidate_o(dc_inv),
      .be_req_o(dc_be_req), .be_addr_o(dc_be_addr), .be_wdata_o(dc_be_wdata),
      .be_wstrb_o(dc_be_wstrb), .be_rdata_i(dc_be_rdata), .be_ack_i(dc_be_ack)
   );

   // Data cache is master 0 so it wins a tie
   bus_merge #(.ADDR_W(ADDR_W)) merge_l1_to_l2 (
      .clk_i(clk_i), .arst_i(arst_i),
      .m0_req_i(dc_be_req), .m0_addr_i(dc_be_addr), .m0_wdata_i(dc_be_wdata),
      .m0_wstrb_i(dc_be_wstrb), .m0_rdata_o(dc_be_rdata), .m0_ack_o(dc_be_ack),
      .m1_req_i(ic_be_req), .m1_addr_i(ic_be_addr), .m1_wdata_i(ic_be_wdata),
      .m1_wstrb_i(ic_be_wstrb), .m1_rdata_o(ic_be_rdata), .m1_ack_o(ic_be_ack),
      .s_req_o(l2_req), .s_addr_o(l2_addr), .s_wdata_o(l2_wdata),
      .s_wstrb_o(l2_wstrb), .s_rdata_i(l2_rdata), .s_ack_i(l2_ack)
   );

   line_cache #(.ADDR_W(ADDR_W), .INDEX_W(L2_INDEX_W), .OFFSET_W(OFFSET_W)) l2cache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(l2_req), .addr_i(l2_addr), .wdata_i(l2_wdata), .wstrb_i(l2_wstrb),
      .rdata_o(l2_rdata), .ack_o(l2_ack),
      .invalidate_i(l2_inv_pending && !l2_req), .invalidate_o(),
      .be_req_o(mem_req_o), .be_addr_o(mem_addr_o), .be_wdata_o(mem_wdata_o),
      .be_wstrb_o(mem_wstrb_o), .be_rdata_i(mem_rdata_i), .be_ack_i(mem_ack_i)
   );

endmodule

// File: logic/bus_merge.sv
`timescale 1ns/100ps

module bus_merge #(
   parameter int ADDR_W = 16
) (
   input  logic                            clk_i,
   input  logic                            arst_i,
   // Master 0, wins a tie
   input  logic                            m0_req_i,
   input  logic [ADDR_W-3:0]               m0_addr_i,
   input  logic [ext_mem_pkg::DATA_W-1:0]  m0_wdata_i,
   input  logic [ext_mem_pkg::STRB_W-1:0]  m0_wstrb_i,
   output logic [ext_mem_pkg::DATA_W-1:0]  m0_rdata_o,
   output logic                            m0_ack_o,
   // Master 1
   input  logic                            m1_req_i,
   input  logic [ADDR_W-3:0]               m1_addr_i,
   input  logic [ext_mem_pkg::DATA_W-1:0]  m1_wdata_i,
   input  logic [ext_mem_pkg::STRB_W-1:0]  m1_wstrb_i,
   output logic [ext_mem_pkg::DATA_W-1:0]  m1_rdata_o,
   output logic                            m1_ack_o,
   // Slave
   output logic                            s_req_o,
   output logic [ADDR_W-3:0]               s_addr_o,
   output logic [ext_mem_pkg::DATA_W-1:0]  s_wdata_o,
   output logic [ext_mem_pkg::STRB_W-1:0]  s_wstrb_o,
   input  logic [ext_mem_pkg::DATA_W-1:0]  s_rdata_i,
   input  logic                            s_ack_i
);

   logic busy_q;   // Grant active
   logic sel_q;    // Granted master

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         sel_q  <= 1'b0;
      end else if (!busy_q) begin
         if (m0_req_i || m1_req_i) begin
            busy_q <= 1'b1;
            sel_q  <= !m0_req_i;
         end
      end else if (s_ack_i) begin
         busy_q <= 1'b0;   // Re-arbitrate next cycle
      end
   end

   assign s_req_o   = busy_q && (sel_q ? m1_req_i : m0_req_i);
   assign s_addr_o  = sel_q ? m1_addr_i  : m0_addr_i;
   assign s_wdata_o = sel_q ? m1_wdata_i : m0_wdata_i;
   assign s_wstrb_o = sel_q ? m1_wstrb_i : m0_wstrb_i;

   assign m0_rdata_o = s_rdata_i;
   assign m1_rdata_o = s_rdata_i;
   assign m0_ack_o   = busy_q && !sel_q && s_ack_i;
   assign m1_ack_o   = busy_q &&  sel_q && s_ack_i;

endmodule

// File: logic/line_cache.sv
`timescale 1ns/100ps

module line_cache #(
   parameter int ADDR_W   = 16,
   parameter int INDEX_W  = 4,
   parameter int OFFSET_W = 2
) (
   input  logic                            clk_i,
   input  logic                            arst_i,
   // Front end
   input  logic                            req_i,
   input  logic [ADDR_W-3:0]               addr_i,
   input  logic [ext_mem_pkg::DATA_W-1:0]  wdata_i,
   input  logic [ext_mem_pkg::STRB_W-1:0]  wstrb_i,
   output logic [ext_mem_pkg::DATA_W-1:0]  rdata_o,
   output logic                            ack_o,
   // Invalidate control
   input  logic                            invalidate_i,
   output logic                            invalidate_o,
   // Back end
   output logic                            be_req_o,
   output logic [ADDR_W-3:0]               be_addr_o,
   output logic [ext_mem_pkg::DATA_W-1:0]  be_wdata_o,
   output logic [ext_mem_pkg::STRB_W-1:0]  be_wstrb_o,
   input  logic [ext_mem_pkg::DATA_W-1:0]  be_rdata_i,
   input  logic                            be_ack_i
);

   localparam int AW    = ADDR_W - 2;
   localparam int TAG_W = AW - INDEX_W - OFFSET_W;
   localparam int LINES = 1 << INDEX_W;
   localparam int WORDS = 1 << (INDEX_W + OFFSET_W);

   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_LOOKUP  = 3'd1;
   localparam logic [2:0] S_REFILL  = 3'd2;
   localparam logic [2:0] S_WRITE   = 3'd3;
   localparam logic [2:0] S_RESPOND = 3'd4;

   logic [2:0]                      state_q, state_d;
   logic [OFFSET_W-1:0]             cnt_q;     // Refill word counter
   logic                            inv_pend_q;
   logic [LINES-1:0]                valid_q;
   logic [TAG_W-1:0]                tag_mem [LINES];
   logic [ext_mem_pkg::DATA_W-1:0]  data_mem [WORDS];

   logic [TAG_W-1:0]                tag;
   logic [INDEX_W-1:0]              idx;
   logic [INDEX_W+OFFSET_W-1:0]     word_sel;
   logic                            hit;
   logic                            is_write;
   logic                            do_inv;
   logic                            refill_done;

   assign tag      = addr_i[AW-1 -: TAG_W];
   assign idx      = addr_i[OFFSET_W +: INDEX_W];
   assign word_sel = addr_i[INDEX_W+OFFSET_W-1:0];
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_write = |wstrb_i;

   // Invalidate only from idle, either fresh or deferred
   assign do_inv       = (state_q == S_IDLE) && (invalidate_i || inv_pend_q);
   assign invalidate_o = do_inv;
   assign refill_done  = (state_q == S_REFILL) && be_ack_i && (&cnt_q);

   // Front end response
   assign rdata_o = data_mem[word_sel];
   assign ack_o   = (state_q == S_RESPOND) ||
                    ((state_q == S_LOOKUP) && !is_write && hit);

   // Back end request, refill walks the line in word order
   assign be_req_o   = (state_q == S_REFILL) || (state_q == S_WRITE);
   assign be_addr_o  = (state_q == S_REFILL) ? {tag, idx, cnt_q} : addr_i;
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = (state_q == S_WRITE) ? wstrb_i : '0;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (!do_inv && req_i) state_d = S_LOOKUP;
         end
         S_LOOKUP: begin
            if (is_write)
               state_d = S_WRITE;
            else if (hit)
               state_d = S_IDLE;   // Hit acked this cycle
            else
               state_d = S_REFILL;
         end
         S_REFILL: begin
            if (refill_done) state_d = S_RESPOND;
         end
         S_WRITE: begin
            if (be_ack_i) state_d = S_RESPOND;
         end
         default: state_d = S_IDLE;  // Respond
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= S_IDLE;
         cnt_q      <= '0;
         inv_pend_q <= 1'b0;
         valid_q    <= '0;
      end else begin
         state_q <= state_d;

         if (do_inv)
            inv_pend_q <= 1'b0;
         else if (invalidate_i)
            inv_pend_q <= 1'b1;   // Busy, hold until idle

         if (state_q == S_LOOKUP)
            cnt_q <= '0;
         else if ((state_q == S_REFILL) && be_ack_i)
            cnt_q <= cnt_q + 1'b1;

         if (do_inv)
            valid_q <= '0;
         else if ((state_q == S_LOOKUP) && !is_write && !hit)
            valid_q[idx] <= 1'b0;  // Line is overwritten during refill
         else if (refill_done)
            valid_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (refill_done) tag_mem[idx] <= tag;
   end

   // Line data, refill words or write-through merge on a hit
   always_ff @(posedge clk_i) begin
      if ((state_q == S_REFILL) && be_ack_i) begin
         data_mem[{idx, cnt_q}] <= be_rdata_i;
      end else if ((state_q == S_WRITE) && be_ack_i && hit) begin
         for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
            if (wstrb_i[b]) data_mem[word_sel][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

endmodule

// File: logic/ext_mem_pkg.sv
// Shared constants for the external-memory subsystem
package ext_mem_pkg;

   // Bus word and byte lanes
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Byte address width seen by the processor ports
   localparam int ADDR_W_DEF = 16;

   // L1 geometry, 16 lines per cache
   localparam int L1_INDEX_W_DEF = 4;

   // L2 geometry, 64 lines
   localparam int L2_INDEX_W_DEF = 6;

   // Words per line as a power of two, same for every level
   localparam int OFFSET_W_DEF = 2;

   // All addresses on the buses are word addresses, ADDR_W - 2 bits wide.
   // A line covers 2**OFFSET_W consecutive words and is fetched in word order.
   // Tag width follows from the address width and the cache geometry:
   //    tag = (ADDR_W - 2) - INDEX_W - OFFSET_W
   // With the defaults this gives 14 - 4 - 2 = 8 tag bits for the L1 caches
   // and 14 - 6 - 2 = 6 tag bits for the L2.

endpackage
